//--- logic/ilk_word_pkg.sv
/*
 * Link word formats for the receive back end.
 * A 65 bit lane word is read either as payload or as a control word.
 * Both views lie over the same bits through link_word_t.
 */
`default_nettype none

package ilk_word_pkg;

	// end of packet code carried by burst and idle control words
	typedef logic [3:0] eop_code_t;

	localparam eop_code_t EOP_NONE = 4'h0;
	localparam eop_code_t EOP_ERR = 4'h1;
	// bit 3 set marks a clean end and bits 2:0 hold valid bytes minus one
	localparam int EOP_END_BIT = 3;

	// data view with bit 64 clear
	typedef struct packed {
		logic        ctrl;
		logic [63:0] payload;
	} data_word_t;

	// control view with bit 64 set
	typedef struct packed {
		logic        ctrl;       // 64
		logic        ctl_type;   // 63 burst or idle control
		logic        burst;      // 62 channel and sop are valid
		logic        sop;        // 61
		eop_code_t   eop_code;   // 60:57
		logic        rst_cal;    // 56
		logic [15:0] flow_ctl;   // 55:40
		logic [7:0]  channel;    // 39:32
		logic [7:0]  multi_use;  // 31:24
		logic [23:0] crc24;      // 23:0
	} ctrl_word_t;

	typedef union packed {
		data_word_t dat;
		ctrl_word_t ctl;
	} link_word_t;

	// true for any code that closes a packet whether clean or errored
	function automatic logic eop_closes(input eop_code_t code);
		return code[EOP_END_BIT] || (code == EOP_ERR);
	endfunction

endpackage

`default_nettype wire

//--- logic/rx_stream_pkg.sv
/*
 * Annotated output stream and statistics record of the receive back end.
 * Beats travel as an array, one rx_beat_t per lane, oldest lane on top.
 */
`default_nettype none

package rx_stream_pkg;

	import ilk_word_pkg::*;

	// widest counter the statistics record carries
	// narrower counters are zero extended into it
	localparam int STATS_W = 64;

	// one output lane whose flags only count with valid set
	typedef struct packed {
		logic [63:0] payload;
		logic        valid;
		logic        sop;
		eop_code_t   eop_code;
	} rx_beat_t;

	typedef struct packed {
		logic [STATS_W-1:0] pkt_cnt;
		logic [STATS_W-1:0] err_cnt;
		logic [STATS_W-1:0] word_cnt;
	} rx_stats_t;

endpackage

`default_nettype wire

//--- logic/rx_word_pack.sv
/*
 * Lane compactor in front of the packet annotator.
 * Valid lane words are moved toward the top lane, oldest first, and
 * counted. One register stage, zeros fill the lanes below the count.
 */
`timescale 1ns/10ps
`default_nettype none

module rx_word_pack
	import ilk_word_pkg::*;
#(
	parameter int WORDS = 4,
	localparam int CW = $clog2(WORDS + 1)
) (
	input  logic                   clk,
	input  logic                   arst,
	input  link_word_t [WORDS-1:0] words_i,
	input  logic [WORDS-1:0]       lane_valid_i,
	output link_word_t [WORDS-1:0] packed_o,
	output logic [CW-1:0]          count_o
);

	link_word_t [WORDS-1:0] packed_d;
	logic [CW-1:0] count_d;

	//////////////////////////////////////////////////
	// compaction
	//////////////////////////////////////////////////

	// walk from the oldest lane down
	// each valid word drops into the next free slot from the top
	always_comb begin
		packed_d = '0;
		count_d = '0;
		for (int i = WORDS - 1; i >= 0; i--) begin
			if (lane_valid_i[i]) begin
				packed_d[WORDS - 1 - count_d] = words_i[i];
				count_d = count_d + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	// count alone qualifies the group downstream
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			count_o <= '0;
		end else begin
			count_o <= count_d;
		end
	end

	always_ff @(posedge clk) begin
		packed_o <= packed_d;
	end

endmodule

`default_nettype wire

//--- logic/rx_packet_annotate.sv
/*
 * Packet annotator. Takes packed lane groups, drops control words and
 * flags payload words with sop and the end of packet code. A group whose
 * bottom word is data waits in the mid stage for the next group, which
 * carries its end code. Output is registered, at least 3 cycles in.
 */
`timescale 1ns/10ps
`default_nettype none

module rx_packet_annotate
	import ilk_word_pkg::*;
	import rx_stream_pkg::*;
#(
	parameter int WORDS = 4,
	localparam int CW = $clog2(WORDS + 1)
) (
	input  logic                   clk,
	input  logic                   arst,
	input  link_word_t [WORDS-1:0] words_i,
	input  logic [CW-1:0]          count_i,
	output rx_beat_t [WORDS-1:0]   beats_o
);

	// input stage
	link_word_t [WORDS-1:0] words_q;
	logic [CW-1:0] count_q;
	logic [WORDS-1:0] in_grp;
	logic [WORDS-1:0] tail_c;
	logic [WORDS-1:0] pay_c;
	logic [WORDS-1:0] sop_c;
	eop_code_t [WORDS-1:0] eop_c;
	logic tail_data_c;
	logic new_grp;
	eop_code_t next_eop;

	// mid stage
	logic [WORDS-1:0][63:0] data_rr;
	logic [WORDS-1:0] pay_rr;
	logic [WORDS-1:0] sop_rr;
	eop_code_t [WORDS-1:0] eop_rr;
	logic [WORDS-1:0] tail_rr;
	logic tail_data_rr;
	logic held_rr;
	logic last_sop_q;

	// release and output stage
	logic rel;
	logic [WORDS-1:0] val_d;
	logic [WORDS-1:0] sop_d;
	eop_code_t [WORDS-1:0] eop_d;
	logic [WORDS-1:0][63:0] out_data_q;
	logic [WORDS-1:0] out_val_q;
	logic [WORDS-1:0] out_sop_q;
	eop_code_t [WORDS-1:0] out_eop_q;

	//////////////////////////////////////////////////
	// input registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			count_q <= '0;
		end else begin
			count_q <= count_i;
		end
	end

	always_ff @(posedge clk) begin
		words_q <= words_i;
	end

	// classify each lane of the registered group
	// lane i is inside the group when count reaches down to it
	always_comb begin
		for (int i = 0; i < WORDS; i++) begin
			in_grp[i] = (count_q >= CW'(WORDS - i));
			tail_c[i] = (count_q == CW'(WORDS - i));
			pay_c[i] = in_grp[i] && !words_q[i].dat.ctrl;
			// only burst control words carry a usable sop
			sop_c[i] = in_grp[i] && words_q[i].ctl.ctrl && words_q[i].ctl.ctl_type &&
				words_q[i].ctl.burst && words_q[i].ctl.sop;
			// burst and idle words both close the previous packet
			if (in_grp[i] && words_q[i].ctl.ctrl && words_q[i].ctl.ctl_type) begin
				eop_c[i] = words_q[i].ctl.eop_code;
			end else begin
				eop_c[i] = EOP_NONE;
			end
		end
		tail_data_c = |(tail_c & pay_c);
		new_grp = (count_q != '0);
		// top word of a new group may close the held group
		next_eop = eop_c[WORDS-1];
	end

	//////////////////////////////////////////////////
	// mid registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			pay_rr <= '0;
			sop_rr <= '0;
			eop_rr <= '0;
			tail_rr <= '0;
			tail_data_rr <= 1'b0;
			held_rr <= 1'b0;
			last_sop_q <= 1'b0;
		end else begin
			if (rel) begin
				held_rr <= 1'b0;
			end
			if (new_grp) begin
				// sop of the outgoing group's bottom word lands on the next top word
				last_sop_q <= |(sop_rr & tail_rr);
				pay_rr <= pay_c;
				sop_rr <= sop_c;
				eop_rr <= eop_c;
				tail_rr <= tail_c;
				tail_data_rr <= tail_data_c;
				held_rr <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (new_grp) begin
			for (int i = 0; i < WORDS; i++) begin
				data_rr[i] <= words_q[i].dat.payload;
			end
		end
	end

	//////////////////////////////////////////////////
	// release and flag placement
	//////////////////////////////////////////////////

	always_comb begin
		// a bottom data word waits for the next group to learn its end code
		rel = held_rr && (!tail_data_rr || new_grp);
		val_d = pay_rr & {WORDS{rel}};
		// sop moves one lane down onto the word after the control word
		sop_d = {last_sop_q, sop_rr[WORDS-1:1]} & val_d;
		// eop moves one lane up onto the word before the control word
		eop_d = {eop_rr[WORDS-2:0], EOP_NONE};
		for (int i = 0; i < WORDS; i++) begin
			if (tail_rr[i] && tail_data_rr) begin
				eop_d[i] = next_eop;
			end
			if (!val_d[i]) begin
				eop_d[i] = EOP_NONE;
			end
		end
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			out_val_q <= '0;
			out_sop_q <= '0;
			out_eop_q <= '0;
		end else begin
			out_val_q <= val_d;
			out_sop_q <= sop_d;
			out_eop_q <= eop_d;
		end
	end

	always_ff @(posedge clk) begin
		out_data_q <= data_rr;
	end

	always_comb begin
		for (int i = 0; i < WORDS; i++) begin
			beats_o[i].payload = out_data_q[i];
			beats_o[i].valid = out_val_q[i];
			beats_o[i].sop = out_sop_q[i];
			beats_o[i].eop_code = out_eop_q[i];
		end
	end

endmodule

`default_nettype wire

//--- logic/rx_packet_stats.sv
/*
 * Stream statistics. Counts payload words, closed packets and errored
 * packets from the annotated beats, one cycle behind them. Counters wrap.
 */
`timescale 1ns/10ps
`default_nettype none

module rx_packet_stats
	import ilk_word_pkg::*;
	import rx_stream_pkg::*;
#(
	parameter int WORDS = 4,
	parameter int CNT_W = 32,
	localparam int CW = $clog2(WORDS + 1)
) (
	input  logic                 clk,
	input  logic                 arst,
	input  rx_beat_t [WORDS-1:0] beats_i,
	output rx_stats_t            stats_o
);

	logic [CW-1:0] n_words;
	logic [CW-1:0] n_pkts;
	logic [CW-1:0] n_errs;
	logic [CNT_W-1:0] pkt_cnt_q;
	logic [CNT_W-1:0] err_cnt_q;
	logic [CNT_W-1:0] word_cnt_q;

	// per cycle tallies over the lane group
	always_comb begin
		n_words = '0;
		n_pkts = '0;
		n_errs = '0;
		for (int i = 0; i < WORDS; i++) begin
			if (beats_i[i].valid) begin
				n_words = n_words + 1'b1;
				if (eop_closes(beats_i[i].eop_code)) begin
					n_pkts = n_pkts + 1'b1;
				end
				if (beats_i[i].eop_code == EOP_ERR) begin
					n_errs = n_errs + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			pkt_cnt_q <= '0;
			err_cnt_q <= '0;
			word_cnt_q <= '0;
		end else begin
			pkt_cnt_q <= pkt_cnt_q + CNT_W'(n_pkts);
			err_cnt_q <= err_cnt_q + CNT_W'(n_errs);
			word_cnt_q <= word_cnt_q + CNT_W'(n_words);
		end
	end

	always_comb begin
		stats_o.pkt_cnt = STATS_W'(pkt_cnt_q);
		stats_o.err_cnt = STATS_W'(err_cnt_q);
		stats_o.word_cnt = STATS_W'(word_cnt_q);
	end

endmodule

`default_nettype wire

//--- logic/rx_annotate_top.sv
/*
 * Receive back end top level. Lane words run through the packer, then
 * the packet annotator, and the statistics watch the annotated beats.
 * Input to output beats takes 4 cycles or more.
 */
`timescale 1ns/10ps
`default_nettype none

module rx_annotate_top
	import ilk_word_pkg::*;
	import rx_stream_pkg::*;
#(
	parameter int WORDS = 4,
	parameter int CNT_W = 32,
	localparam int CW = $clog2(WORDS + 1)
) (
	input  logic                   clk,
	input  logic                   arst,
	input  link_word_t [WORDS-1:0] words_i,
	input  logic [WORDS-1:0]       lane_valid_i,
	output rx_beat_t [WORDS-1:0]   beats_o,
	output rx_stats_t              stats_o
);

	// packed group between packer and annotator
	link_word_t [WORDS-1:0] packed_w;
	logic [CW-1:0] count_w;

	rx_word_pack #(
		.WORDS (WORDS)
	) u_pack (
		.clk          (clk),
		.arst         (arst),
		.words_i      (words_i),
		.lane_valid_i (lane_valid_i),
		.packed_o     (packed_w),
		.count_o      (count_w)
	);

	rx_packet_annotate #(
		.WORDS (WORDS)
	) u_annotate (
		.clk     (clk),
		.arst    (arst),
		.words_i (packed_w),
		.count_i (count_w),
		.beats_o (beats_o)
	);

	// statistics tap the same beats that leave the block
	rx_packet_stats #(
		.WORDS (WORDS),
		.CNT_W (CNT_W)
	) u_stats (
		.clk     (clk),
		.arst    (arst),
		.beats_i (beats_o),
		.stats_o (stats_o)
	);

endmodule

`default_nettype wire

//--- dv/rx_annotate_assert.sv
/*
 * Concurrent checks on the annotator output beats, bound into every
 * rx_packet_annotate instance. fired counts the failures for the testbench.
 */
`timescale 1ns/10ps
`default_nettype none

module rx_annotate_assert
	import ilk_word_pkg::*;
	import rx_stream_pkg::*;
#(
	parameter int WORDS = 4
) (
	input logic                 clk,
	input logic                 arst,
	input rx_beat_t [WORDS-1:0] beats_i
);

	int unsigned fired = 0;

	for (genvar i = 0; i < WORDS; i++) begin : g_lane
		// sop and end codes ride on valid beats only
		flags_need_valid: assert property (@(posedge clk) disable iff (arst)
			(beats_i[i].sop || beats_i[i].eop_code != EOP_NONE) |-> beats_i[i].valid)
		else begin
			$error("lane %0d shows sop or an end code without valid", i);
			fired++;
		end

		// nothing leaves while reset is held
		quiet_in_reset: assert property (@(posedge clk) arst |-> !beats_i[i].valid)
		else begin
			$error("lane %0d valid during reset", i);
			fired++;
		end
	end

endmodule

bind rx_packet_annotate rx_annotate_assert #(
	.WORDS (WORDS)
) u_assert (
	.clk     (clk),
	.arst    (arst),
	.beats_i (beats_o)
);

`default_nettype wire

//--- dv/tb_rx_annotate.sv
/*
 * Testbench for the receive back end. Builds a random packet stream,
 * scatters it over random lane masks and checks the annotated beats and
 * the statistics against a stream order reference model.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_rx_annotate
	import ilk_word_pkg::*;
	import rx_stream_pkg::*;
();

	localparam int WORDS = 4;
	localparam int N_PKTS = 60;
	localparam int RST_CYCLES = 16;

	logic clk;
	logic arst;
	link_word_t [WORDS-1:0] words_i;
	logic [WORDS-1:0] lane_valid_i;
	rx_beat_t [WORDS-1:0] beats_o;
	rx_stats_t stats_o;

	// generated word stream, expected beats and the per cycle lane schedule
	link_word_t stream_q[$];
	rx_beat_t want_q[$];
	link_word_t [WORDS-1:0] sched_words_q[$];
	logic [WORDS-1:0] sched_mask_q[$];
	int unsigned n_data;
	int unsigned n_pkt;
	int unsigned n_err;

	logic [31:0] lfsr_q;
	logic sched_ready;
	logic mon_en;
	int unsigned errors;
	int unsigned tests_pass;
	int unsigned tests_fail;

	rx_annotate_top #(
		.WORDS (WORDS),
		.CNT_W (32)
	) UUT (
		.clk          (clk),
		.arst         (arst),
		.words_i      (words_i),
		.lane_valid_i (lane_valid_i),
		.beats_o      (beats_o),
		.stats_o      (stats_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic link_word_t make_ctrl(input logic burst, input logic sop,
			input eop_code_t code);
		link_word_t w;
		w = '0;
		w.ctl.ctrl = 1'b1;
		w.ctl.ctl_type = 1'b1;
		w.ctl.burst = burst;
		w.ctl.sop = sop;
		w.ctl.eop_code = code;
		w.ctl.channel = 8'(take_bits(8));
		return w;
	endfunction

	// data word into the stream and its matching beat into the model
	task automatic add_data(input logic sop);
		link_word_t w;
		rx_beat_t b;
		w = '0;
		w.dat.payload = {take_bits(32), take_bits(32)};
		stream_q.push_back(w);
		b = '0;
		b.payload = w.dat.payload;
		b.valid = 1'b1;
		b.sop = sop;
		want_q.push_back(b);
		n_data++;
	endtask

	task automatic build_stream();
		int unsigned len;
		eop_code_t code;
		rx_beat_t last;
		for (int p = 0; p < N_PKTS; p++) begin
			stream_q.push_back(make_ctrl(1'b1, 1'b1, EOP_NONE));
			len = 1 + take_bits(4) % 12;
			for (int d = 0; d < len; d++) begin
				add_data(d == 0);
			end
			// mostly clean ends with a byte count and now and then an error
			if (take_bits(3) == 0) begin
				code = EOP_ERR;
				n_err++;
			end else begin
				code = 4'h8 | eop_code_t'(take_bits(3));
			end
			last = want_q[want_q.size() - 1];
			last.eop_code = code;
			want_q[want_q.size() - 1] = last;
			n_pkt++;
			// closing word is a burst without sop or an idle
			stream_q.push_back(make_ctrl(take_bits(1) != 0, 1'b0, code));
			repeat (take_bits(2)) begin
				stream_q.push_back(make_ctrl(1'b0, 1'b0, EOP_NONE));
			end
		end
	endtask

	task automatic build_schedule();
		link_word_t [WORDS-1:0] lanes;
		logic [WORDS-1:0] mask;
		int unsigned idx;
		idx = 0;
		while (idx < stream_q.size()) begin
			// roughly one cycle in four forced empty
			if (take_bits(2) == 0) begin
				mask = '0;
			end else begin
				mask = WORDS'(take_bits(WORDS));
			end
			for (int i = WORDS - 1; i >= 0; i--) begin
				if (mask[i] && idx < stream_q.size()) begin
					lanes[i] = stream_q[idx];
					idx++;
				end else begin
					mask[i] = 1'b0;
					// empty lanes hold a control word with every flag set
					lanes[i] = '1;
				end
			end
			sched_words_q.push_back(lanes);
			sched_mask_q.push_back(mask);
		end
	endtask

	//////////////////////////////////////////////////
	// checks and report
	//////////////////////////////////////////////////

	task automatic compare_beat(input rx_beat_t want, input rx_beat_t act, input string what);
		if (act !== want) begin
			$display("[FAIL] %t %s: expected %h v%b s%b e%h, got %h v%b s%b e%h",
				$time, what, want.payload, want.valid, want.sop, want.eop_code,
				act.payload, act.valid, act.sop, act.eop_code);
			errors++;
		end
	endtask

	task automatic compare_stats(input rx_stats_t want, input rx_stats_t act, input string what);
		if (act !== want) begin
			$display("[FAIL] %t %s: expected pkt %0d err %0d word %0d, got %0d %0d %0d",
				$time, what, want.pkt_cnt, want.err_cnt, want.word_cnt,
				act.pkt_cnt, act.err_cnt, act.word_cnt);
			errors++;
		end
	endtask

	task automatic close_test(input string name, input int unsigned err_base);
		if (errors == err_base) begin
			tests_pass++;
			$display("test %s passed", name);
		end else begin
			tests_fail++;
			$display("test %s failed with %0d mismatches", name, errors - err_base);
		end
	endtask

	// outputs only move on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		rx_beat_t want;
		if (mon_en) begin
			for (int i = WORDS - 1; i >= 0; i--) begin
				if (beats_o[i].valid === 1'b1) begin
					if (want_q.size() == 0) begin
						$display("unexpected beat on lane %0d at %t with no data left", i, $time);
						errors++;
					end else begin
						want = want_q.pop_front();
						compare_beat(want, beats_o[i], "stream beat");
					end
				end
			end
		end
	end

	initial begin
		int unsigned limit;
		wait (sched_ready === 1'b1);
		// reset, idle checks, every scheduled cycle and room to drain
		limit = RST_CYCLES + 8 + sched_mask_q.size() + 200;
		#(limit * 4);
		$display("timeout: stream not drained after %0d cycles, %0d beats still expected",
			limit, want_q.size());
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		rx_beat_t act;
		rx_stats_t want_stats;
		int unsigned base;
		$timeformat(-9, 2, " ns", 10);
		arst = 1'b1;
		words_i = '0;
		lane_valid_i = '0;
		lfsr_q = 32'h9aab;
		sched_ready = 1'b0;
		mon_en = 1'b0;
		errors = 0;
		tests_pass = 0;
		tests_fail = 0;
		n_data = 0;
		n_pkt = 0;
		n_err = 0;
		build_stream();
		build_schedule();
		sched_ready = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		arst = 1'b0;

		// quiet link after reset
		base = errors;
		want_stats = '0;
		repeat (4) begin
			@(negedge clk);
			for (int i = 0; i < WORDS; i++) begin
				act = beats_o[i];
				// payload carries nothing until the first group leaves
				act.payload = '0;
				compare_beat('0, act, "idle beat");
			end
			compare_stats(want_stats, stats_o, "idle stats");
		end
		close_test("reset_idle", base);

		// payload order, sop and eop placement
		base = errors;
		mon_en = 1'b1;
		while (sched_mask_q.size() != 0) begin
			@(negedge clk);
			words_i = sched_words_q.pop_front();
			lane_valid_i = sched_mask_q.pop_front();
		end
		@(negedge clk);
		words_i = '0;
		lane_valid_i = '0;
		while (want_q.size() != 0) begin
			@(negedge clk);
		end
		close_test("stream_beats", base);

		// counters trail the beats by one cycle
		base = errors;
		repeat (2) @(negedge clk);
		want_stats.pkt_cnt = n_pkt;
		want_stats.err_cnt = n_err;
		want_stats.word_cnt = n_data;
		compare_stats(want_stats, stats_o, "drained stats");
		close_test("stats", base);

		base = errors;
		if (UUT.u_annotate.u_assert.fired != 0) begin
			$display("annotator assertions failed %0d times", UUT.u_annotate.u_assert.fired);
			errors += UUT.u_annotate.u_assert.fired;
		end
		close_test("assertions", base);

		$display("tests passed %0d, failed %0d, mismatches %0d", tests_pass, tests_fail, errors);
		if (tests_fail == 0 && errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
logic/ilk_word_pkg.sv
logic/rx_stream_pkg.sv
logic/rx_word_pack.sv
logic/rx_packet_annotate.sv
logic/rx_packet_stats.sv
logic/rx_annotate_top.sv
dv/rx_annotate_assert.sv
dv/tb_rx_annotate.sv

//--- Bender.yml
package:
  name: rx_annotate

sources:
  - logic/ilk_word_pkg.sv
  - logic/rx_stream_pkg.sv
  - logic/rx_word_pack.sv
  - logic/rx_packet_annotate.sv
  - logic/rx_packet_stats.sv
  - logic/rx_annotate_top.sv
  - target: test
    files:
      - dv/rx_annotate_assert.sv
      - dv/tb_rx_annotate.sv
